/* bench/conv_accel_tb.sv */
`timescale 1ns/100ps
`include "conv_accel_config.svh"

module conv_accel_tb import conv_accel_pkg::*; ();

    // upper bounds on instructions issued by each test group
    localparam int TXN_FULL     = 2 * 35;
    localparam int TXN_PARTIAL  = 2 * 18;
    localparam int TXN_OVERFLOW = 39;
    localparam int TXN_CLEAR    = 38;
    localparam int TXN_IGNORE   = 30;
    localparam int CYCLE_LIMIT  =
        (TXN_FULL + TXN_PARTIAL + TXN_OVERFLOW + TXN_CLEAR + TXN_IGNORE) * 40 + 100;

    localparam logic [6:0] FOREIGN_OPCODE = 7'b0101011;

    logic     clk_i;
    logic     rst_i;
    logic     accel_en_i;
    logic     insn_valid_i;
    insn_t    insn_i;
    word_t    rs1_i;
    word_t    rs2_i;
    word_t    result_o;
    reg_idx_t result_rd_o;
    logic     result_valid_o;

    // reference model state
    word_t                mf [`CA_DEPTH];
    word_t                md [`CA_DEPTH];
    logic [`CA_DEPTH-1:0] mk_f;
    logic [`CA_DEPTH-1:0] mk_d;
    int                   pf;
    int                   pd;
    word_t                held_result; // what result_o should show between pulses

    logic [31:0] lfsr_q = 32'd2;
    int          value_errs = 0;
    int          pulse_errs = 0;
    int          cyc;
    logic        mon_en = 1'b0;
    logic        pulse_due = 1'b0;

    conv_accel_top dut (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .accel_en_i     (accel_en_i),
        .insn_valid_i   (insn_valid_i),
        .insn_i         (insn_i),
        .rs1_i          (rs1_i),
        .rs2_i          (rs2_i),
        .result_o       (result_o),
        .result_rd_o    (result_rd_o),
        .result_valid_o (result_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic insn_t make_insn(input logic [6:0] opc, input logic [2:0] f3,
                                        input logic pair, input reg_idx_t rd);
        insn_t v;
        v = '0;
        v[6:0] = opc;
        v[11:7] = rd;
        v[14:12] = f3;
        v[25 + `CA_PAIR_BIT] = pair;
        return v;
    endfunction

    // sum over the leading run of slots filled on both sides
    function automatic word_t model_sum();
        word_t s;
        int    k;
        s = '0;
        k = 0;
        while (k < `CA_DEPTH && mk_f[k] && mk_d[k]) begin
            s = s + mf[k] * md[k]; // product keeps only the low 32 bits
            k++;
        end
        return s;
    endfunction

    task automatic model_load(input logic filt, input logic pair, input word_t w1,
                              input word_t w2);
        int step;
        step = pair ? 2 : 1;
        if (filt) begin
            if (pf < `CA_DEPTH) begin
                mf[pf] = w1;
                mk_f[pf] = 1'b1;
            end
            if (pair && pf + 1 < `CA_DEPTH) begin
                mf[pf + 1] = w2;
                mk_f[pf + 1] = 1'b1;
            end
            pf = (pf + step > `CA_DEPTH) ? `CA_DEPTH : pf + step;
        end else begin
            if (pd < `CA_DEPTH) begin
                md[pd] = w1;
                mk_d[pd] = 1'b1;
            end
            if (pair && pd + 1 < `CA_DEPTH) begin
                md[pd + 1] = w2;
                mk_d[pd + 1] = 1'b1;
            end
            pd = (pd + step > `CA_DEPTH) ? `CA_DEPTH : pd + step;
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_rd(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("Mismatch %s: got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_valid(input logic got);
        if (got !== 1'b1) begin
            pulse_errs++;
            $display("result_valid_o did not pulse two cycles after an accepted run");
        end
    endtask

    // one instruction, held for a single cycle
    task automatic issue(input insn_t insn, input word_t a, input word_t b);
        @(posedge clk_i);
        insn_valid_i <= 1'b1;
        insn_i       <= insn;
        rs1_i        <= a;
        rs2_i        <= b;
        @(posedge clk_i);
        insn_valid_i <= 1'b0;
    endtask

    task automatic load_one(input logic filt, input logic pair);
        word_t w1;
        word_t w2;
        w1 = rand_bits(32);
        w2 = rand_bits(32);
        issue(make_insn(`CA_OPCODE, filt ? `CA_F3_LDF : `CA_F3_LDD, pair, '0), w1, w2);
        model_load(filt, pair, w1, w2);
    endtask

    task automatic load_words(input logic filt, input int n);
        int   cnt;
        logic pair;
        cnt = 0;
        while (cnt < n) begin
            pair = (n - cnt >= 2) && (rand_bits(1) == 1);
            load_one(filt, pair);
            cnt += pair ? 2 : 1;
        end
    endtask

    // both buffers to 16 words, singles and pairs in random order
    task automatic fill_both_full();
        logic filt;
        logic pair;
        int   ptr;
        while (pf < `CA_DEPTH || pd < `CA_DEPTH) begin
            if (pf >= `CA_DEPTH) filt = 1'b0;
            else if (pd >= `CA_DEPTH) filt = 1'b1;
            else filt = (rand_bits(1) == 1);
            ptr = filt ? pf : pd;
            pair = (ptr <= `CA_DEPTH - 2) && (rand_bits(1) == 1);
            load_one(filt, pair);
        end
    endtask

    task automatic clear_buf(input logic filt);
        issue(make_insn(`CA_OPCODE, filt ? `CA_F3_CLRF : `CA_F3_CLRD, 1'b0, '0), '0, '0);
        if (filt) begin
            mk_f = '0;
            pf = 0;
        end else begin
            mk_d = '0;
            pd = 0;
        end
        held_result = '0;
    endtask

    // run after gap idle cycles, then check the pulse cycle
    task automatic run_check(input int gap);
        reg_idx_t rd;
        word_t    exp;
        rd = reg_idx_t'(rand_bits(5));
        exp = model_sum();
        repeat (gap) @(posedge clk_i);
        issue(make_insn(`CA_OPCODE, `CA_F3_RUN, 1'b0, rd), '0, '0);
        @(posedge clk_i);
        pulse_due = 1'b1;
        @(negedge clk_i);
        check_valid(result_valid_o);
        check_word("result_o", result_o, exp);
        check_rd("result_rd_o", result_rd_o, rd);
        held_result = exp;
        @(posedge clk_i);
        pulse_due = 1'b0;
    endtask

    // any valid pulse that no run asked for
    always @(negedge clk_i) begin
        if (mon_en && !pulse_due && result_valid_o !== 1'b0) begin
            pulse_errs++;
            $display("result_valid_o was high with no run pending");
        end
    end

    initial begin
        cyc = 0;
        while (cyc < CYCLE_LIMIT) begin
            @(posedge clk_i);
            cyc++;
        end
        $display("timeout after %0d cycles, the test sequence did not complete", CYCLE_LIMIT);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        rst_i        = 1'b1;
        accel_en_i   = 1'b1;
        insn_valid_i = 1'b0;
        insn_i       = '0;
        rs1_i        = '0;
        rs2_i        = '0;
        mk_f         = '0;
        mk_d         = '0;
        pf           = 0;
        pd           = 0;
        held_result  = '0;
        repeat (3) @(posedge clk_i);
        rst_i  <= 1'b0;
        mon_en = 1'b1;

        // full dot products
        for (int r = 0; r < 2; r++) begin
            clear_buf(1'b1);
            clear_buf(1'b0);
            fill_both_full();
            run_check(20);
        end

        // partial fills
        clear_buf(1'b1);
        clear_buf(1'b0);
        load_words(1'b1, 9);
        load_words(1'b0, 5);
        run_check(20);
        clear_buf(1'b1);
        clear_buf(1'b0);
        load_words(1'b1, 4);
        load_words(1'b0, 11);
        run_check(20);

        // overflow, including a pair starting at the last slot
        clear_buf(1'b1);
        clear_buf(1'b0);
        load_words(1'b1, 15);
        load_one(1'b1, 1'b1);
        load_words(1'b0, 20);
        run_check(20);

        // clears give zero right away, reloads give a fresh sum
        clear_buf(1'b1);
        run_check(0);
        load_words(1'b1, 16);
        run_check(20);
        clear_buf(1'b0);
        run_check(0);
        load_words(1'b0, 16);
        run_check(20);

        // instructions that must be ignored
        clear_buf(1'b1);
        clear_buf(1'b0);
        load_words(1'b1, 6);
        load_words(1'b0, 8); // a stray filter load would lengthen the sum
        run_check(20);
        issue(make_insn(FOREIGN_OPCODE, `CA_F3_LDF, 1'b1, '0), rand_bits(32), rand_bits(32));
        issue(make_insn(FOREIGN_OPCODE, `CA_F3_CLRF, 1'b0, '0), '0, '0);
        issue(make_insn(FOREIGN_OPCODE, `CA_F3_RUN, 1'b0, 5'd3), '0, '0);
        issue(make_insn(`CA_OPCODE, 3'b101, 1'b1, '0), rand_bits(32), rand_bits(32));
        issue(make_insn(`CA_OPCODE, 3'b110, 1'b0, '0), rand_bits(32), rand_bits(32));
        issue(make_insn(`CA_OPCODE, 3'b111, 1'b1, '0), rand_bits(32), rand_bits(32));
        @(posedge clk_i);
        accel_en_i <= 1'b0;
        issue(make_insn(`CA_OPCODE, `CA_F3_LDF, 1'b1, '0), rand_bits(32), rand_bits(32));
        issue(make_insn(`CA_OPCODE, `CA_F3_CLRD, 1'b0, '0), '0, '0);
        issue(make_insn(`CA_OPCODE, `CA_F3_RUN, 1'b0, 5'd7), '0, '0);
        repeat (4) @(posedge clk_i);
        accel_en_i <= 1'b1;
        @(negedge clk_i);
        check_word("result_o", result_o, held_result); // untouched by any of the above
        run_check(20);

        repeat (4) @(posedge clk_i);
        $display("errors: %0d value mismatches, %0d valid pulse errors", value_errs, pulse_errs);
        if (value_errs == 0 && pulse_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* common/conv_accel_config.svh */
`ifndef CONV_ACCEL_CONFIG_SVH
`define CONV_ACCEL_CONFIG_SVH

// slots in each operand buffer
`define CA_DEPTH 16

// custom-0 major opcode
`define CA_OPCODE 7'b0001011

// funct3 command codes
`define CA_F3_LDF  3'b000
`define CA_F3_LDD  3'b001
`define CA_F3_CLRF 3'b010
`define CA_F3_CLRD 3'b011
`define CA_F3_RUN  3'b100

// funct7 bit that turns a load into a pair load (rs1 and rs2)
`define CA_PAIR_BIT 0

`endif

/* common/conv_accel_pkg.sv */
package conv_accel_pkg;

    // operand, product and running sum, all 32-bit unsigned
    typedef logic [31:0] word_t;

    // one of the 16 slots of a buffer
    typedef logic [3:0] slot_idx_t;

    // one bit wider than a slot index so that 16 can mean full
    typedef logic [4:0] wr_ptr_t;

    // destination register of the run instruction
    typedef logic [4:0] reg_idx_t;

    // raw instruction word from the decode stage
    typedef logic [31:0] insn_t;

    // the engine walks the slots, then parks in DONE after the last one
    typedef enum logic {
        IDLE_WALK = 1'b0, // waiting on or adding the current slot
        DONE      = 1'b1  // last slot added, held until a clear
    } eng_state_t;

endpackage

/* conv_accel.f */
+incdir+common
common/conv_accel_pkg.sv
hw/insn_decoder.sv
hw/operand_buffer.sv
dot_engine/dot_engine.sv
hw/result_stage.sv
hw/conv_accel_top.sv
bench/conv_accel_tb.sv

/* dot_engine/dot_engine.sv */
`timescale 1ns/100ps
`include "conv_accel_config.svh"

module dot_engine import conv_accel_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      clr_filter_i,
    input  logic      clr_data_i,
    input  word_t     f_word_i,
    input  word_t     d_word_i,
    input  logic      f_filled_i,
    input  logic      d_filled_i,
    output slot_idx_t rd_idx_o,
    output word_t     acc_next_o
);

    localparam slot_idx_t LAST_SLOT = slot_idx_t'(`CA_DEPTH - 1);

    eng_state_t state;
    eng_state_t state_next;
    slot_idx_t  idx;
    slot_idx_t  idx_next;
    word_t      acc;
    word_t      acc_next;
    word_t      product;
    logic       take;
    logic       clr;

    assign clr = clr_filter_i || clr_data_i; // either buffer restarts the walk

    // low 32 bits of the product only
    assign product = f_word_i * d_word_i;

    // current slot is used once both halves have arrived
    assign take = (state == IDLE_WALK) && f_filled_i && d_filled_i;

    always_comb begin
        state_next = state;
        idx_next   = idx;
        acc_next   = acc;
        if (take) begin
            acc_next = acc + product; // wraps
            if (idx == LAST_SLOT) begin
                state_next = DONE;
            end else begin
                idx_next = idx + slot_idx_t'(1);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= IDLE_WALK;
            idx   <= '0;
            acc   <= '0;
        end else if (clr) begin
            state <= IDLE_WALK;
            idx   <= '0;
            acc   <= '0;
        end else begin
            state <= state_next;
            idx   <= idx_next;
            acc   <= acc_next;
        end
    end

    // both buffers are read at the slot being walked
    assign rd_idx_o = idx;

    // the result stage sees the sum with this cycle's product included
    assign acc_next_o = acc_next;

endmodule

/* hw/conv_accel_top.sv */
`timescale 1ns/100ps

module conv_accel_top import conv_accel_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     accel_en_i,
    input  logic     insn_valid_i,
    input  insn_t    insn_i,
    input  word_t    rs1_i,
    input  word_t    rs2_i,
    output word_t    result_o,
    output reg_idx_t result_rd_o,
    output logic     result_valid_o
);

    logic      ldf;
    logic      ldd;
    logic      pair;
    logic      clrf;
    logic      clrd;
    logic      run;
    reg_idx_t  run_rd;
    word_t     op1;
    word_t     op2;
    slot_idx_t rd_idx;
    word_t     f_word;
    word_t     d_word;
    logic      f_filled;
    logic      d_filled;
    word_t     acc_next;

    insn_decoder u_decoder (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .accel_en_i   (accel_en_i),
        .insn_valid_i (insn_valid_i),
        .insn_i       (insn_i),
        .rs1_i        (rs1_i),
        .rs2_i        (rs2_i),
        .ldf_o        (ldf),
        .ldd_o        (ldd),
        .pair_o       (pair),
        .clrf_o       (clrf),
        .clrd_o       (clrd),
        .run_o        (run),
        .rd_o         (run_rd),
        .op1_o        (op1),
        .op2_o        (op2)
    );

    // filter words
    operand_buffer u_filter (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .wr_en_i     (ldf),
        .wr_pair_i   (pair),
        .clr_i       (clrf),
        .wr_word1_i  (op1),
        .wr_word2_i  (op2),
        .rd_idx_i    (rd_idx),
        .rd_word_o   (f_word),
        .rd_filled_o (f_filled)
    );

    // data window words
    operand_buffer u_data (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .wr_en_i     (ldd),
        .wr_pair_i   (pair),
        .clr_i       (clrd),
        .wr_word1_i  (op1),
        .wr_word2_i  (op2),
        .rd_idx_i    (rd_idx),
        .rd_word_o   (d_word),
        .rd_filled_o (d_filled)
    );

    dot_engine u_engine (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .clr_filter_i (clrf),
        .clr_data_i   (clrd),
        .f_word_i     (f_word),
        .d_word_i     (d_word),
        .f_filled_i   (f_filled),
        .d_filled_i   (d_filled),
        .rd_idx_o     (rd_idx),
        .acc_next_o   (acc_next)
    );

    result_stage u_result (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .run_i          (run),
        .run_rd_i       (run_rd),
        .clr_filter_i   (clrf),
        .clr_data_i     (clrd),
        .acc_next_i     (acc_next),
        .result_o       (result_o),
        .result_rd_o    (result_rd_o),
        .result_valid_o (result_valid_o)
    );

endmodule

/* hw/insn_decoder.sv */
`timescale 1ns/100ps
`include "conv_accel_config.svh"

module insn_decoder import conv_accel_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     accel_en_i,
    input  logic     insn_valid_i,
    input  insn_t    insn_i,
    input  word_t    rs1_i,
    input  word_t    rs2_i,
    output logic     ldf_o,
    output logic     ldd_o,
    output logic     pair_o,
    output logic     clrf_o,
    output logic     clrd_o,
    output logic     run_o,
    output reg_idx_t rd_o,
    output word_t    op1_o,
    output word_t    op2_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       accept;
    logic       dec_ldf;
    logic       dec_ldd;
    logic       dec_clrf;
    logic       dec_clrd;
    logic       dec_run;
    logic       dec_pair;

    assign opcode = insn_i[6:0];
    assign funct3 = insn_i[14:12];
    assign funct7 = insn_i[31:25];

    // only custom-0 instructions while the block is enabled
    assign accept = accel_en_i && insn_valid_i && (opcode == `CA_OPCODE);

    always_comb begin
        dec_ldf  = 1'b0;
        dec_ldd  = 1'b0;
        dec_clrf = 1'b0;
        dec_clrd = 1'b0;
        dec_run  = 1'b0;
        if (accept) begin
            case (funct3)
                `CA_F3_LDF:  dec_ldf  = 1'b1;
                `CA_F3_LDD:  dec_ldd  = 1'b1;
                `CA_F3_CLRF: dec_clrf = 1'b1;
                `CA_F3_CLRD: dec_clrd = 1'b1;
                `CA_F3_RUN:  dec_run  = 1'b1;
                default:     dec_run  = 1'b0; // unused funct3 decodes to nothing
            endcase
        end
    end

    // pair flag only means something alongside a load
    assign dec_pair = (dec_ldf || dec_ldd) && funct7[`CA_PAIR_BIT];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ldf_o  <= 1'b0;
            ldd_o  <= 1'b0;
            pair_o <= 1'b0;
            clrf_o <= 1'b0;
            clrd_o <= 1'b0;
            run_o  <= 1'b0;
        end else begin
            ldf_o  <= dec_ldf; // one cycle strobes
            ldd_o  <= dec_ldd;
            pair_o <= dec_pair;
            clrf_o <= dec_clrf;
            clrd_o <= dec_clrd;
            run_o  <= dec_run;
        end
    end

    // operands and rd ride along with the strobe of the same instruction
    always_ff @(posedge clk_i) begin
        if (accept) begin
            rd_o  <= insn_i[11:7];
            op1_o <= rs1_i;
            op2_o <= rs2_i;
        end
    end

endmodule

/* hw/operand_buffer.sv */
`timescale 1ns/100ps
`include "conv_accel_config.svh"

module operand_buffer import conv_accel_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      wr_en_i,
    input  logic      wr_pair_i,
    input  logic      clr_i,
    input  word_t     wr_word1_i,
    input  word_t     wr_word2_i,
    input  slot_idx_t rd_idx_i,
    output word_t     rd_word_o,
    output logic      rd_filled_o
);

    word_t                words [`CA_DEPTH];
    logic [`CA_DEPTH-1:0] mask;        // one bit per slot that holds a word
    wr_ptr_t              wr_ptr;      // 16 means full
    wr_ptr_t              ptr_plus1;
    wr_ptr_t              ptr_next;
    slot_idx_t            wr_slot1;
    slot_idx_t            wr_slot2;
    logic                 wr1_ok;
    logic                 wr2_ok;

    assign ptr_plus1 = wr_ptr + wr_ptr_t'(1);
    assign wr_slot1  = slot_idx_t'(wr_ptr);
    assign wr_slot2  = slot_idx_t'(ptr_plus1);

    // anything past the last slot is dropped
    assign wr1_ok = wr_en_i && (wr_ptr < `CA_DEPTH);
    assign wr2_ok = wr_en_i && wr_pair_i && (ptr_plus1 < `CA_DEPTH);

    // pointer saturates at the end of the buffer
    always_comb begin
        ptr_next = wr_pair_i ? (wr_ptr + wr_ptr_t'(2)) : ptr_plus1;
        if (ptr_next > `CA_DEPTH) begin
            ptr_next = wr_ptr_t'(`CA_DEPTH);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mask   <= '0;
            wr_ptr <= '0;
        end else if (clr_i) begin
            mask   <= '0;
            wr_ptr <= '0;
        end else if (wr_en_i) begin
            wr_ptr <= ptr_next;
            if (wr1_ok) mask[wr_slot1] <= 1'b1;
            if (wr2_ok) mask[wr_slot2] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (clr_i) begin
            for (int i = 0; i < `CA_DEPTH; i++) begin
                words[i] <= '0;
            end
        end else begin
            if (wr1_ok) words[wr_slot1] <= wr_word1_i; // rs1 at the pointer
            if (wr2_ok) words[wr_slot2] <= wr_word2_i; // rs2 right after it
        end
    end

    assign rd_word_o   = words[rd_idx_i];
    assign rd_filled_o = mask[rd_idx_i];

endmodule

/* hw/result_stage.sv */
`timescale 1ns/100ps

module result_stage import conv_accel_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     run_i,
    input  reg_idx_t run_rd_i,
    input  logic     clr_filter_i,
    input  logic     clr_data_i,
    input  word_t    acc_next_i,
    output word_t    result_o,
    output reg_idx_t result_rd_o,
    output logic     result_valid_o
);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            result_o       <= '0;
            result_rd_o    <= '0;
            result_valid_o <= 1'b0;
        end else begin
            result_valid_o <= run_i; // single cycle pulse per run
            if (clr_filter_i || clr_data_i) begin
                result_o <= '0;
            end else if (run_i) begin
                result_o    <= acc_next_i;
                result_rd_o <= run_rd_i;
            end
        end
    end

endmodule
